// File: bench/cpuCoreTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuCoreTb
    import cpuPkg::*;
();

    localparam int NUM_ROWS = 6;
    localparam int RUN_LIMIT = 150;
    localparam int SETTLE_CYCLES = 6;
    localparam int WATCHDOG_NS = NUM_ROWS * 200 * 40;

    logic  Clk = 1'b0;
    logic  rst;
    word_t instrAddress;
    logic  instrRead;
    word_t instrData;
    word_t dataAddress;
    logic  dataRead;
    logic  dataWrite;
    word_t dataWriteValue;
    word_t dataReadValue;
    word_t outputPort;
    logic  outputValid;
    word_t numInst;
    logic  halted;

    word_t instrMem [256];
    word_t dataMem [256];

    // Test table indexed by row
    string      names [NUM_ROWS];
    instr_t     progs [NUM_ROWS][16];
    int         progLen [NUM_ROWS];
    word_t      dataInit [NUM_ROWS][4];
    word_t      expOut [NUM_ROWS][4];
    int         outLen [NUM_ROWS];
    word_t      expCount [NUM_ROWS];
    logic [7:0] checkAddr [NUM_ROWS];
    word_t      checkValue [NUM_ROWS];

    int    currentRow = 0;
    int    errorCount = 0;
    int    passedTests = 0;
    logic  collecting = 1'b0;
    word_t outputs [$];

    cpuCore dut0 (
        .Clk(Clk),
        .rst(rst),
        .instrAddress(instrAddress),
        .instrRead(instrRead),
        .instrData(instrData),
        .dataAddress(dataAddress),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataWriteValue(dataWriteValue),
        .dataReadValue(dataReadValue),
        .outputPort(outputPort),
        .outputValid(outputValid),
        .numInst(numInst),
        .halted(halted)
    );

    always #20 Clk = ~Clk;

    // Memories answer only while the core requests a read
    assign instrData = instrRead ? instrMem[instrAddress[7:0]] : '0;
    assign dataReadValue = dataRead ? dataMem[dataAddress[7:0]] : '0;

    // Data memory reloads from the current row while in reset
    always @(posedge Clk) begin
        if (rst) begin
            for (int a = 0; a < 256; a++) begin
                if (a < 4) begin
                    dataMem[a] <= dataInit[currentRow][a];
                end else begin
                    dataMem[a] <= {~8'(a), 8'(a)};
                end
            end
        end else if (dataWrite) begin
            dataMem[dataAddress[7:0]] <= dataWriteValue;
        end
    end

    always @(negedge Clk) begin
        if (collecting && outputValid) begin
            outputs.push_back(outputPort);
        end
    end

    function automatic instr_t encodeR(func_t fn, regIdx_t rs, regIdx_t rt, regIdx_t rd);
        instr_t ins;
        ins.rForm.opcode = OP_RTYPE;
        ins.rForm.rs = rs;
        ins.rForm.rt = rt;
        ins.rForm.rd = rd;
        ins.rForm.func = fn;
        return ins;
    endfunction

    function automatic instr_t encodeI(opcode_t op, regIdx_t rs, regIdx_t rt, logic [7:0] imm);
        instr_t ins;
        ins.iForm.opcode = op;
        ins.iForm.rs = rs;
        ins.iForm.rt = rt;
        ins.iForm.imm = imm;
        return ins;
    endfunction

    function automatic instr_t encodeJ(opcode_t op, logic [11:0] target);
        instr_t ins;
        ins.jForm.opcode = op;
        ins.jForm.target = target;
        return ins;
    endfunction

    task automatic describeRow(int row, string name, word_t count, logic [7:0] addr,
                               word_t value);
        names[row] = name;
        expCount[row] = count;
        checkAddr[row] = addr;
        checkValue[row] = value;
        progLen[row] = 0;
        outLen[row] = 0;
        for (int k = 0; k < 4; k++) begin
            dataInit[row][k] = '0;
        end
    endtask

    task automatic addInstr(int row, instr_t ins);
        progs[row][progLen[row]] = ins;
        progLen[row]++;
    endtask

    task automatic addOutput(int row, word_t value);
        expOut[row][outLen[row]] = value;
        outLen[row]++;
    endtask

    task automatic buildTable();
        logic [7:0] imm;
        word_t      sum;
        // Chain of dependent ALU ops
        describeRow(0, "alu", 16'd11, 8'h90, 16'h6f90);
        addInstr(0, encodeI(OP_LHI, 2'd0, 2'd1, 8'h12));
        addInstr(0, encodeI(OP_ORI, 2'd1, 2'd1, 8'h34));
        addInstr(0, encodeI(OP_ADI, 2'd1, 2'd2, 8'hff));
        addInstr(0, encodeR(FN_ADD, 2'd1, 2'd2, 2'd3));
        addInstr(0, encodeR(FN_WWD, 2'd3, 2'd0, 2'd0));
        addInstr(0, encodeR(FN_SUB, 2'd2, 2'd3, 2'd0));
        addInstr(0, encodeR(FN_AND, 2'd0, 2'd1, 2'd1));
        addInstr(0, encodeR(FN_ORR, 2'd1, 2'd2, 2'd2));
        addInstr(0, encodeR(FN_WWD, 2'd0, 2'd0, 2'd0));
        addInstr(0, encodeR(FN_WWD, 2'd2, 2'd0, 2'd0));
        addInstr(0, encodeR(FN_HLT, 2'd0, 2'd0, 2'd0));
        addOutput(0, 16'h1234 + 16'h1233);
        addOutput(0, 16'h1233 - 16'h2467);
        addOutput(0, (16'hedcc & 16'h1234) | 16'h1233);
        // Loads with dependent ADDs and a store then reload
        describeRow(1, "memory", 16'd11, 8'h90, 16'hbeef);
        dataInit[1][2] = 16'h0300;
        dataInit[1][3] = 16'h0044;
        addInstr(1, encodeI(OP_LHI, 2'd0, 2'd0, 8'h00));
        addInstr(1, encodeI(OP_LWD, 2'd0, 2'd1, 8'h03));
        addInstr(1, encodeR(FN_ADD, 2'd1, 2'd1, 2'd2));
        addInstr(1, encodeI(OP_LHI, 2'd0, 2'd3, 8'hbe));
        addInstr(1, encodeI(OP_ORI, 2'd3, 2'd3, 8'hef));
        addInstr(1, encodeI(OP_SWD, 2'd2, 2'd3, 8'h08));
        addInstr(1, encodeI(OP_LWD, 2'd2, 2'd1, 8'h08));
        addInstr(1, encodeR(FN_ADD, 2'd1, 2'd2, 2'd0));
        addInstr(1, encodeR(FN_WWD, 2'd2, 2'd0, 2'd0));
        addInstr(1, encodeR(FN_WWD, 2'd0, 2'd0, 2'd0));
        addInstr(1, encodeR(FN_HLT, 2'd0, 2'd0, 2'd0));
        addOutput(1, 16'h0044 + 16'h0044);
        addOutput(1, 16'hbeef + 16'h0088);
        // Taken and untaken BEQ and BNE
        describeRow(2, "branch", 16'd11, 8'h90, 16'h6f90);
        addInstr(2, encodeI(OP_LHI, 2'd0, 2'd0, 8'h00));
        addInstr(2, encodeI(OP_ADI, 2'd0, 2'd1, 8'h03));
        addInstr(2, encodeI(OP_ADI, 2'd0, 2'd2, 8'h03));
        addInstr(2, encodeI(OP_BEQ, 2'd1, 2'd2, 8'h01));
        addInstr(2, encodeR(FN_WWD, 2'd1, 2'd0, 2'd0));
        addInstr(2, encodeI(OP_BNE, 2'd1, 2'd2, 8'h01));
        addInstr(2, encodeI(OP_ADI, 2'd1, 2'd3, 8'h10));
        addInstr(2, encodeR(FN_WWD, 2'd3, 2'd0, 2'd0));
        addInstr(2, encodeI(OP_BNE, 2'd1, 2'd3, 8'h01));
        addInstr(2, encodeR(FN_WWD, 2'd1, 2'd0, 2'd0));
        addInstr(2, encodeI(OP_BEQ, 2'd1, 2'd3, 8'h01));
        addInstr(2, encodeR(FN_WWD, 2'd1, 2'd0, 2'd0));
        addInstr(2, encodeR(FN_HLT, 2'd0, 2'd0, 2'd0));
        addOutput(2, 16'd3 + 16'h0010);
        addOutput(2, 16'd3);
        // JMP over a WWD then JAL out and JPR back to the link
        describeRow(3, "jumps", 16'd9, 8'h90, 16'h6f90);
        addInstr(3, encodeI(OP_LHI, 2'd0, 2'd0, 8'h00));
        addInstr(3, encodeJ(OP_JMP, 12'd3));
        addInstr(3, encodeR(FN_WWD, 2'd0, 2'd0, 2'd0));
        addInstr(3, encodeJ(OP_JAL, 12'd6));
        addInstr(3, encodeR(FN_WWD, 2'd2, 2'd0, 2'd0));
        addInstr(3, encodeR(FN_HLT, 2'd0, 2'd0, 2'd0));
        addInstr(3, encodeR(FN_WWD, 2'd2, 2'd0, 2'd0));
        addInstr(3, encodeI(OP_ADI, 2'd0, 2'd1, 8'h21));
        addInstr(3, encodeR(FN_WWD, 2'd1, 2'd0, 2'd0));
        addInstr(3, encodeR(FN_JPR, 2'd2, 2'd0, 2'd0));
        addOutput(3, 16'd3 + 16'd1);
        addOutput(3, 16'h0021);
        addOutput(3, 16'd3 + 16'd1);
        // Nothing after HLT may retire
        describeRow(4, "halt", 16'd3, 8'h90, 16'h6f90);
        addInstr(4, encodeI(OP_LHI, 2'd0, 2'd0, 8'h7f));
        addInstr(4, encodeR(FN_WWD, 2'd0, 2'd0, 2'd0));
        addInstr(4, encodeR(FN_HLT, 2'd0, 2'd0, 2'd0));
        addInstr(4, encodeR(FN_WWD, 2'd0, 2'd0, 2'd0));
        addInstr(4, encodeR(FN_WWD, 2'd0, 2'd0, 2'd0));
        addOutput(4, 16'h7f00);
        // Random immediates summed with sign extension
        describeRow(5, "random", 16'd11, 8'h90, 16'h6f90);
        addInstr(5, encodeI(OP_LHI, 2'd0, 2'd0, 8'h00));
        sum = '0;
        for (int k = 0; k < 8; k++) begin
            imm = 8'($urandom);
            sum = sum + {{8{imm[7]}}, imm};
            addInstr(5, encodeI(OP_ADI, 2'd0, 2'd0, imm));
        end
        addInstr(5, encodeR(FN_WWD, 2'd0, 2'd0, 2'd0));
        addInstr(5, encodeR(FN_HLT, 2'd0, 2'd0, 2'd0));
        addOutput(5, sum);
    endtask

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkCount(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s retire count expected %0d actual %0d", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic runTest(int row);
        int startErrors;
        int cycles;
        startErrors = errorCount;
        currentRow = row;
        @(posedge Clk);
        rst <= 1'b1;
        for (int a = 0; a < 256; a++) begin
            if (a < progLen[row]) begin
                instrMem[a] = progs[row][a];
            end else begin
                // Self loop so a runaway never halts
                instrMem[a] = encodeJ(OP_JMP, 12'(a));
            end
        end
        repeat (4) @(posedge Clk);
        rst <= 1'b0;
        outputs.delete();
        collecting = 1'b1;
        cycles = 0;
        while (!halted && cycles < RUN_LIMIT) begin
            @(negedge Clk);
            cycles++;
        end
        if (!halted) begin
            $display("Test %s never halted within %0d cycles", names[row], RUN_LIMIT);
            errorCount++;
        end else begin
            repeat (SETTLE_CYCLES) @(negedge Clk);
            if (!halted) begin
                $display("Test %s: halted dropped after it was raised", names[row]);
                errorCount++;
            end
            if (outputs.size() != outLen[row]) begin
                $display("Test %s produced %0d outputs instead of %0d", names[row],
                         outputs.size(), outLen[row]);
                errorCount++;
            end else begin
                for (int i = 0; i < outLen[row]; i++) begin
                    checkWord($sformatf("%s output %0d", names[row], i), expOut[row][i],
                              outputs[i]);
                end
            end
            checkCount(names[row], expCount[row], numInst);
            checkWord($sformatf("%s memory[%h]", names[row], checkAddr[row]),
                      checkValue[row], dataMem[checkAddr[row]]);
        end
        collecting = 1'b0;
        $display("Test %s finished with %0d errors", names[row], errorCount - startErrors);
        if (errorCount == startErrors) begin
            passedTests++;
        end
    endtask

    initial begin
        rst = 1'b1;
        void'($urandom(32'h081c_941b));
        buildTable();
        for (int row = 0; row < NUM_ROWS; row++) begin
            runTest(row);
        end
        $display("Summary: %0d/%0d tests clean, %0d errors, %0d assertion failures",
                 passedTests, NUM_ROWS, errorCount, dut0.assertions0.failures);
        if (errorCount == 0 && dut0.assertions0.failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test loop finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/cpuCore_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module cpuCore_assertions
    import cpuPkg::*;
(
    input logic  Clk,
    input logic  rst,
    input logic  outputValid,
    input logic  halted,
    input logic  instrRead,
    input word_t instrAddress,
    input logic  dataRead,
    input logic  dataWrite
);

    int failures = 0;

    // Retire outputs leave reset clear
    resetClear: assert property (@(posedge Clk) rst |=> !outputValid && !halted)
        else begin
            $error("outputValid or halted high in the cycle after reset");
            failures++;
        end

    haltSticky: assert property (@(posedge Clk) disable iff (rst) halted |=> halted)
        else begin
            $error("halted dropped without a reset");
            failures++;
        end

    // Fetch stops once halted
    haltNoFetch: assert property (@(posedge Clk) disable iff (rst)
                                  halted |-> !instrRead && $stable(instrAddress))
        else begin
            $error("instrRead high or fetch address moving while halted");
            failures++;
        end

    memExclusive: assert property (@(posedge Clk) !(dataRead && dataWrite))
        else begin
            $error("dataRead and dataWrite high together");
            failures++;
        end

endmodule

bind cpuCore cpuCore_assertions assertions0 (
    .Clk(Clk),
    .rst(rst),
    .outputValid(outputValid),
    .halted(halted),
    .instrRead(instrRead),
    .instrAddress(instrAddress),
    .dataRead(dataRead),
    .dataWrite(dataWrite)
);

`default_nettype wire

// File: filelist.f
logic/cpuPkg.sv
logic/stageBuses.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memWriteback.sv
logic/cpuCore.sv
bench/cpuCore_assertions.sv
bench/cpuCoreTb.sv

// File: logic/cpuCore.sv
`timescale 1ns/10ps
`default_nettype none

module cpuCore
    import cpuPkg::*;
(
    input  logic  Clk,
    input  logic  rst,
    output word_t instrAddress,
    output logic  instrRead,
    input  word_t instrData,
    output word_t dataAddress,
    output logic  dataRead,
    output logic  dataWrite,
    output word_t dataWriteValue,
    input  word_t dataReadValue,
    output word_t outputPort,
    output logic  outputValid,
    output word_t numInst,
    output logic  halted
);

    word_t   ifPc;
    instr_t  ifInstr;
    logic    ifValid;
    logic    stall;
    logic    frozen;
    logic    jumpTaken;
    word_t   jumpTarget;
    logic    redirect;
    word_t   redirectTarget;
    logic    wbWrite;
    regIdx_t wbRd;
    word_t   wbData;

    decExBus idEx();
    exMemBus exMem();

    fetchStage fetch0 (
        .Clk(Clk),
        .rst(rst),
        .stall(stall),
        .frozen(frozen),
        .jumpTaken(jumpTaken),
        .jumpTarget(jumpTarget),
        .redirect(redirect),
        .redirectTarget(redirectTarget),
        .halted(halted),
        .instrAddress(instrAddress),
        .instrRead(instrRead),
        .instrData(instrData),
        .ifPc(ifPc),
        .ifInstr(ifInstr),
        .ifValid(ifValid)
    );

    decodeStage decode0 (
        .Clk(Clk),
        .rst(rst),
        .ifPc(ifPc),
        .ifInstr(ifInstr),
        .ifValid(ifValid),
        .stall(stall),
        .frozen(frozen),
        .jumpTaken(jumpTaken),
        .jumpTarget(jumpTarget),
        .redirect(redirect),
        .wbWrite(wbWrite),
        .wbRd(wbRd),
        .wbData(wbData),
        .idEx(idEx.source)
    );

    executeStage execute0 (
        .Clk(Clk),
        .rst(rst),
        .idEx(idEx.sink),
        .exMem(exMem.source),
        .wbWrite(wbWrite),
        .wbRd(wbRd),
        .wbData(wbData),
        .redirect(redirect),
        .redirectTarget(redirectTarget)
    );

    memWriteback memWb0 (
        .Clk(Clk),
        .rst(rst),
        .exMem(exMem.sink),
        .dataAddress(dataAddress),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataWriteValue(dataWriteValue),
        .dataReadValue(dataReadValue),
        .wbWrite(wbWrite),
        .wbRd(wbRd),
        .wbData(wbData),
        .outputPort(outputPort),
        .outputValid(outputValid),
        .numInst(numInst),
        .halted(halted)
    );

endmodule

`default_nettype wire

// File: logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  regIdx_t;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_JAL   = 4'd10,
        OP_RTYPE = 4'd15
    } opcode_t;

    // Low two bits of the ALU codes match aluOp_t
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_JPR = 6'd25,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_t;

    typedef union packed {
        struct packed {
            opcode_t opcode;
            regIdx_t rs;
            regIdx_t rt;
            regIdx_t rd;
            func_t   func;
        } rForm;
        struct packed {
            opcode_t    opcode;
            regIdx_t    rs;
            regIdx_t    rt;
            logic [7:0] imm;
        } iForm;
        struct packed {
            opcode_t     opcode;
            logic [11:0] target;
        } jForm;
    } instr_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } aluOp_t;

    typedef struct packed {
        logic   regWrite;
        logic   memToReg;
        logic   memWrite;
        logic   memRead;
        logic   isBranch;
        logic   isJumpR;
        logic   aluSrcImm;
        logic   isWwd;
        logic   isHalt;
        aluOp_t aluOp;
    } ctrl_t;

    localparam regIdx_t JAL_LINK_REG = 2'd2;

endpackage

`default_nettype wire

// File: logic/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage
    import cpuPkg::*;
(
    input  logic    Clk,
    input  logic    rst,
    input  word_t   ifPc,
    input  instr_t  ifInstr,
    input  logic    ifValid,
    output logic    stall,
    output logic    frozen,
    output logic    jumpTaken,
    output word_t   jumpTarget,
    input  logic    redirect,
    input  logic    wbWrite,
    input  regIdx_t wbRd,
    input  word_t   wbData,
    decExBus.source idEx
);

    word_t   regFile [4];
    ctrl_t   decCtrl;
    regIdx_t dest;
    word_t   immExt;
    word_t   pcPlus1;
    word_t   readData1;
    word_t   readData2;
    logic    usesRs;
    logic    usesRt;
    logic    isLhiNext;
    logic    isJump;
    logic    loadUse;
    logic    haltNow;
    logic    frozenReg;

    assign pcPlus1 = ifPc + 16'd1;

    always_comb begin
        decCtrl = '0;
        decCtrl.aluOp = ALU_ADD;
        dest = ifInstr.iForm.rt;
        immExt = {{8{ifInstr.iForm.imm[7]}}, ifInstr.iForm.imm};
        usesRs = 1'b1;
        usesRt = 1'b0;
        isLhiNext = 1'b0;
        isJump = 1'b0;
        case (ifInstr.rForm.opcode)
            OP_RTYPE: begin
                dest = ifInstr.rForm.rd;
                case (ifInstr.rForm.func)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
                        decCtrl.regWrite = 1'b1;
                        decCtrl.aluOp = aluOp_t'(ifInstr.rForm.func[1:0]);
                        usesRt = 1'b1;
                    end
                    FN_JPR: decCtrl.isJumpR = 1'b1;
                    FN_WWD: begin
                        // rs passes through the ALU untouched
                        decCtrl.isWwd = 1'b1;
                        decCtrl.aluSrcImm = 1'b1;
                        decCtrl.aluOp = ALU_OR;
                        immExt = '0;
                    end
                    FN_HLT: begin
                        decCtrl.isHalt = 1'b1;
                        usesRs = 1'b0;
                    end
                    default: usesRs = 1'b0;
                endcase
            end
            OP_ADI: begin
                decCtrl.regWrite = 1'b1;
                decCtrl.aluSrcImm = 1'b1;
            end
            OP_ORI: begin
                // Zero-extended, unlike the other immediates
                decCtrl.regWrite = 1'b1;
                decCtrl.aluSrcImm = 1'b1;
                decCtrl.aluOp = ALU_OR;
                immExt = {8'h00, ifInstr.iForm.imm};
            end
            OP_LHI: begin
                decCtrl.regWrite = 1'b1;
                decCtrl.aluSrcImm = 1'b1;
                isLhiNext = 1'b1;
                immExt = {ifInstr.iForm.imm, 8'h00};
                usesRs = 1'b0;
            end
            OP_LWD: begin
                decCtrl.regWrite = 1'b1;
                decCtrl.memToReg = 1'b1;
                decCtrl.memRead = 1'b1;
                decCtrl.aluSrcImm = 1'b1;
            end
            OP_SWD: begin
                decCtrl.memWrite = 1'b1;
                decCtrl.aluSrcImm = 1'b1;
                usesRt = 1'b1;
            end
            OP_BNE: begin
                decCtrl.isBranch = 1'b1;
                decCtrl.aluOp = ALU_SUB;
                usesRt = 1'b1;
            end
            OP_BEQ: begin
                decCtrl.isBranch = 1'b1;
                usesRt = 1'b1;
            end
            OP_JMP: begin
                isJump = 1'b1;
                usesRs = 1'b0;
            end
            OP_JAL: begin
                // Link value rides the upper-immediate path
                isJump = 1'b1;
                decCtrl.regWrite = 1'b1;
                decCtrl.aluSrcImm = 1'b1;
                isLhiNext = 1'b1;
                dest = JAL_LINK_REG;
                immExt = pcPlus1;
                usesRs = 1'b0;
            end
            default: usesRs = 1'b0;
        endcase
    end

    // Same-cycle write is visible to the read
    assign readData1 = (wbWrite && wbRd == ifInstr.rForm.rs) ? wbData
                                                              : regFile[ifInstr.rForm.rs];
    assign readData2 = (wbWrite && wbRd == ifInstr.rForm.rt) ? wbData
                                                              : regFile[ifInstr.rForm.rt];

    always_ff @(posedge Clk) begin
        if (wbWrite) begin
            regFile[wbRd] <= wbData;
        end
    end

    assign loadUse = ifValid && idEx.valid && idEx.ctrl.memRead &&
                     ((usesRs && ifInstr.rForm.rs == idEx.rd) ||
                      (usesRt && ifInstr.rForm.rt == idEx.rd));
    assign stall = loadUse && !redirect;

    assign jumpTaken = ifValid && isJump && !redirect;
    assign jumpTarget = {ifPc[15:12], ifInstr.jForm.target};

    assign haltNow = ifValid && decCtrl.isHalt && !redirect;
    assign frozen = frozenReg || haltNow;

    always_ff @(posedge Clk) begin
        if (rst) begin
            frozenReg <= 1'b0;
        end else if (haltNow) begin
            frozenReg <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            idEx.valid <= 1'b0;
            idEx.ctrl <= '0;
        end else if (redirect || stall || !ifValid) begin
            idEx.valid <= 1'b0;
            idEx.ctrl <= '0;
        end else begin
            idEx.valid <= 1'b1;
            idEx.ctrl <= decCtrl;
        end
    end

    always_ff @(posedge Clk) begin
        idEx.pc <= ifPc;
        idEx.aluOp <= decCtrl.aluOp;
        idEx.rs <= ifInstr.rForm.rs;
        idEx.rt <= ifInstr.rForm.rt;
        idEx.rd <= dest;
        idEx.readData1 <= readData1;
        idEx.readData2 <= readData2;
        idEx.imm <= immExt;
        idEx.isLhi <= isLhiNext;
    end

endmodule

`default_nettype wire

// File: logic/executeStage.sv
`timescale 1ns/10ps
`default_nettype none

module executeStage
    import cpuPkg::*;
(
    input  logic    Clk,
    input  logic    rst,
    decExBus.sink   idEx,
    exMemBus.source exMem,
    input  logic    wbWrite,
    input  regIdx_t wbRd,
    input  word_t   wbData,
    output logic    redirect,
    output word_t   redirectTarget
);

    word_t operandA;
    word_t operandB;
    word_t aluA;
    word_t aluB;
    word_t aluOut;
    word_t branchTarget;
    logic  branchTaken;

    // Newest producer first; loads in EX/MEM are covered by the decode stall
    function automatic word_t forwardValue(input regIdx_t src, input word_t regValue);
        if (exMem.valid && exMem.ctrl.regWrite && !exMem.ctrl.memToReg &&
            exMem.rd == src) begin
            return exMem.aluResult;
        end else if (wbWrite && wbRd == src) begin
            return wbData;
        end
        return regValue;
    endfunction

    always_comb begin
        operandA = forwardValue(idEx.rs, idEx.readData1);
        operandB = forwardValue(idEx.rt, idEx.readData2);
    end

    // LHI and the JAL link add their prepared immediate to zero
    assign aluA = idEx.isLhi ? '0 : operandA;
    assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : operandB;

    always_comb begin
        case (idEx.aluOp)
            ALU_ADD: aluOut = aluA + aluB;
            ALU_SUB: aluOut = aluA - aluB;
            ALU_AND: aluOut = aluA & aluB;
            default: aluOut = aluA | aluB;
        endcase
    end

    // Branch sense comes from aluOp, SUB marks BNE
    assign branchTaken = idEx.ctrl.isBranch &&
                         ((idEx.aluOp == ALU_SUB) ? (operandA != operandB)
                                                  : (operandA == operandB));
    assign branchTarget = idEx.pc + 16'd1 + idEx.imm;

    assign redirect = branchTaken || idEx.ctrl.isJumpR;
    assign redirectTarget = idEx.ctrl.isJumpR ? operandA : branchTarget;

    always_ff @(posedge Clk) begin
        if (rst) begin
            exMem.valid <= 1'b0;
            exMem.ctrl <= '0;
        end else begin
            exMem.valid <= idEx.valid;
            exMem.ctrl <= idEx.ctrl;
        end
    end

    always_ff @(posedge Clk) begin
        exMem.aluResult <= aluOut;
        exMem.storeData <= operandB;
        exMem.rd <= idEx.rd;
    end

endmodule

`default_nettype wire

// File: logic/fetchStage.sv
`timescale 1ns/10ps
`default_nettype none

module fetchStage
    import cpuPkg::*;
(
    input  logic   Clk,
    input  logic   rst,
    input  logic   stall,
    input  logic   frozen,
    input  logic   jumpTaken,
    input  word_t  jumpTarget,
    input  logic   redirect,
    input  word_t  redirectTarget,
    input  logic   halted,
    output word_t  instrAddress,
    output logic   instrRead,
    input  word_t  instrData,
    output word_t  ifPc,
    output instr_t ifInstr,
    output logic   ifValid
);

    word_t pc;

    assign instrAddress = pc;
    assign instrRead = !halted;

    // Execute redirect wins over a decode jump
    always_ff @(posedge Clk) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirectTarget;
        end else if (stall || frozen) begin
            pc <= pc;
        end else if (jumpTaken) begin
            pc <= jumpTarget;
        end else begin
            pc <= pc + 16'd1;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            ifValid <= 1'b0;
        end else if (redirect || jumpTaken || frozen) begin
            ifValid <= 1'b0;
        end else if (!stall) begin
            ifValid <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (!stall) begin
            ifPc <= pc;
            ifInstr <= instrData;
        end
    end

endmodule

`default_nettype wire

// File: logic/memWriteback.sv
`timescale 1ns/10ps
`default_nettype none

module memWriteback
    import cpuPkg::*;
(
    input  logic    Clk,
    input  logic    rst,
    exMemBus.sink   exMem,
    output word_t   dataAddress,
    output logic    dataRead,
    output logic    dataWrite,
    output word_t   dataWriteValue,
    input  word_t   dataReadValue,
    output logic    wbWrite,
    output regIdx_t wbRd,
    output word_t   wbData,
    output word_t   outputPort,
    output logic    outputValid,
    output word_t   numInst,
    output logic    halted
);

    logic  wbValid;
    ctrl_t wbCtrl;
    word_t wbAlu;
    word_t wbLoad;

    // Data memory answers in the same cycle
    assign dataAddress = exMem.aluResult;
    assign dataRead = exMem.ctrl.memRead;
    assign dataWrite = exMem.ctrl.memWrite;
    assign dataWriteValue = exMem.storeData;

    always_ff @(posedge Clk) begin
        if (rst) begin
            wbValid <= 1'b0;
            wbCtrl <= '0;
        end else begin
            wbValid <= exMem.valid;
            wbCtrl <= exMem.ctrl;
        end
    end

    always_ff @(posedge Clk) begin
        wbAlu <= exMem.aluResult;
        wbLoad <= dataReadValue;
        wbRd <= exMem.rd;
    end

    assign wbWrite = wbCtrl.regWrite;
    assign wbData = wbCtrl.memToReg ? wbLoad : wbAlu;

    // Retire side effects
    always_ff @(posedge Clk) begin
        if (rst) begin
            outputValid <= 1'b0;
            numInst <= '0;
            halted <= 1'b0;
        end else begin
            outputValid <= wbValid && wbCtrl.isWwd;
            if (wbValid) begin
                numInst <= numInst + 16'd1;
            end
            if (wbValid && wbCtrl.isHalt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (wbValid && wbCtrl.isWwd) begin
            outputPort <= wbAlu;
        end
    end

endmodule

`default_nettype wire

// File: logic/stageBuses.sv
`timescale 1ns/10ps
`default_nettype none

// ID/EX latch contents
interface decExBus
    import cpuPkg::*;
();
    logic    valid;
    word_t   pc;
    ctrl_t   ctrl;
    aluOp_t  aluOp;
    regIdx_t rs;
    regIdx_t rt;
    regIdx_t rd;
    word_t   readData1;
    word_t   readData2;
    word_t   imm;
    logic    isLhi;

    modport source (output valid, pc, ctrl, aluOp, rs, rt, rd,
                    readData1, readData2, imm, isLhi);
    modport sink (input valid, pc, ctrl, aluOp, rs, rt, rd,
                  readData1, readData2, imm, isLhi);
endinterface

// EX/MEM latch contents
interface exMemBus
    import cpuPkg::*;
();
    logic    valid;
    ctrl_t   ctrl;
    word_t   aluResult;
    word_t   storeData;
    regIdx_t rd;

    modport source (output valid, ctrl, aluResult, storeData, rd);
    modport sink (input valid, ctrl, aluResult, storeData, rd);
endinterface

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Compile and run the cpuCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module cpuCoreTb -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

simOutput=$(./obj_dir/VcpuCoreTb)
status=$?
echo "$simOutput"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$simOutput" | grep -qx "All tests passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
